// File: build.f
logic/mem_cfg_pkg.sv
logic/mem_cmd_pkg.sv
logic/mem_port_if.sv
logic/bytewrite_tdp_ram.sv
logic/cmd_decode.sv
logic/fill_execute.sv
logic/result_stage.sv
logic/mem_engine_top.sv
test/mem_engine_tb.sv

// File: logic/bytewrite_tdp_ram.sv
// True dual-port RAM with byte column writes, write-first on both ports
// Both ports run on clka; one cycle read latency, dout holds while en is low

module bytewrite_tdp_ram #(
  parameter int NB_COL    = mem_cfg_pkg::NB_COL,
  parameter int COL_WIDTH = mem_cfg_pkg::COL_WIDTH,
  parameter int RAM_DEPTH = mem_cfg_pkg::RAM_DEPTH
) (
  input logic     clka,
  mem_port_if.ram a,
  mem_port_if.ram b
);

  localparam int WORD_W = NB_COL * COL_WIDTH;

  logic [WORD_W-1:0] mem [RAM_DEPTH];  // Storage, not reset

  // Column loop per port; port B is applied after port A
  always_ff @(posedge clka) begin
    if (a.en) begin
      for (int i = 0; i < NB_COL; i++) begin
        if (a.we[i]) begin
          mem[a.addr][i*COL_WIDTH +: COL_WIDTH] <= a.din[i*COL_WIDTH +: COL_WIDTH];
          a.dout[i*COL_WIDTH +: COL_WIDTH]      <= a.din[i*COL_WIDTH +: COL_WIDTH];  // New byte
        end else begin
          a.dout[i*COL_WIDTH +: COL_WIDTH] <= mem[a.addr][i*COL_WIDTH +: COL_WIDTH];  // Old byte
        end
      end
    end
    if (b.en) begin
      for (int i = 0; i < NB_COL; i++) begin
        if (b.we[i]) begin
          mem[b.addr][i*COL_WIDTH +: COL_WIDTH] <= b.din[i*COL_WIDTH +: COL_WIDTH];
          b.dout[i*COL_WIDTH +: COL_WIDTH]      <= b.din[i*COL_WIDTH +: COL_WIDTH];
        end else begin
          b.dout[i*COL_WIDTH +: COL_WIDTH] <= mem[b.addr][i*COL_WIDTH +: COL_WIDTH];
        end
      end
    end
  end

  // Host and fill engine must never write the same bytes of one word together
  a_no_write_collision : assert property (
    @(posedge clka)
    !(a.en && b.en && (a.addr == b.addr) && |(a.we & b.we))
  ) else $error("Port A and port B write the same bytes at address %0h", a.addr);

endmodule

// File: logic/cmd_decode.sv
// Host command decoder
// Registers one strobe per cycle into a port A access, a fill request
// or an illegal-opcode tag, all valid the cycle after the strobe

module cmd_decode (
  input  logic                             clka,
  input  logic                             reset,
  input  logic                             cmd_valid,  // One-cycle command strobe
  input  logic [1:0]                       cmd_op,
  input  logic [mem_cfg_pkg::ADDR_W-1:0]   cmd_addr,
  input  logic [mem_cfg_pkg::WORD_W-1:0]   cmd_data,
  input  logic [mem_cfg_pkg::NB_COL-1:0]   cmd_be,     // WRITE byte mask
  input  logic [mem_cfg_pkg::LEN_W-1:0]    cmd_len,    // FILL word count
  mem_port_if.user                         port_a,
  output logic                             fill_start,
  output logic [mem_cfg_pkg::ADDR_W-1:0]   fill_addr,
  output logic [mem_cfg_pkg::WORD_W-1:0]   fill_data,
  output logic [mem_cfg_pkg::LEN_W-1:0]    fill_len,
  output logic                             rd_tag,     // Port A returns data next cycle
  output logic                             bad_op_tag
);

  mem_cmd_pkg::mem_op_t op;
  logic                 is_access;  // READ or WRITE
  logic                 is_fill;
  logic                 is_bad;

  assign op = mem_cmd_pkg::mem_op_t'(cmd_op);

  // Opcode decode, qualified by the strobe
  always_comb begin
    is_access = 1'b0;
    is_fill   = 1'b0;
    is_bad    = 1'b0;
    case (op)
      mem_cmd_pkg::OP_READ,
      mem_cmd_pkg::OP_WRITE: is_access = cmd_valid;
      mem_cmd_pkg::OP_FILL:  is_fill   = cmd_valid;
      default:               is_bad    = cmd_valid;  // OP_RSVD
    endcase
  end

  // Control flags
  always_ff @(posedge clka) begin
    if (reset) begin
      port_a.en  <= 1'b0;
      rd_tag     <= 1'b0;
      fill_start <= 1'b0;
      bad_op_tag <= 1'b0;
    end else begin
      port_a.en  <= is_access;
      rd_tag     <= is_access;  // Writes also return the merged word
      fill_start <= is_fill;
      bad_op_tag <= is_bad;
    end
  end

  // Payload, captured every cycle
  always_ff @(posedge clka) begin
    port_a.we   <= (op == mem_cmd_pkg::OP_WRITE) ? cmd_be : '0;  // READ uses empty mask
    port_a.addr <= cmd_addr;
    port_a.din  <= cmd_data;
    fill_addr   <= cmd_addr;
    fill_data   <= cmd_data;
    fill_len    <= cmd_len;
  end

  // An illegal opcode must never reach the RAM
  a_bad_op_no_access : assert property (
    @(posedge clka) disable iff (reset)
    !(bad_op_tag && port_a.en)
  ) else $error("Illegal opcode drove a port A access");

endmodule

// File: logic/fill_execute.sv
// Background fill engine on RAM port B
// Takes one request at a time and writes the pattern one word per cycle,
// wrapping at the top address; requests while busy are rejected

module fill_execute (
  input  logic                           clka,
  input  logic                           reset,
  input  logic                           fill_start,
  input  logic [mem_cfg_pkg::ADDR_W-1:0] fill_addr,
  input  logic [mem_cfg_pkg::WORD_W-1:0] fill_data,
  input  logic [mem_cfg_pkg::LEN_W-1:0]  fill_len,
  mem_port_if.user                       port_b,
  output logic                           busy,
  output logic                           fill_done,   // Pulse, first idle cycle
  output logic                           fill_reject  // Pulse, request dropped
);

  mem_cmd_pkg::fill_state_t             state;
  logic [mem_cfg_pkg::ADDR_W-1:0]       cur_addr;   // Next word to write
  logic [mem_cfg_pkg::ADDR_W-1:0]       next_addr;
  logic [mem_cfg_pkg::WORD_W-1:0]       pattern;
  logic [mem_cfg_pkg::LEN_W-1:0]        remain;     // Words still to write
  logic                                 accept;

  assign accept = fill_start && (state == mem_cmd_pkg::FILL_IDLE);

  // Wrap modulo depth, also for depths that are not a power of two
  assign next_addr = (cur_addr == mem_cfg_pkg::ADDR_W'(mem_cfg_pkg::RAM_DEPTH - 1)) ?
                     '0 : cur_addr + 1'b1;

  assign busy        = (state == mem_cmd_pkg::FILL_RUN);
  assign port_b.en   = busy;
  assign port_b.we   = '1;  // Full words only
  assign port_b.addr = cur_addr;
  assign port_b.din  = pattern;

  always_ff @(posedge clka) begin
    if (reset) begin
      state       <= mem_cmd_pkg::FILL_IDLE;
      remain      <= '0;
      fill_done   <= 1'b0;
      fill_reject <= 1'b0;
    end else begin
      fill_done   <= 1'b0;
      fill_reject <= fill_start && !accept;
      case (state)
        mem_cmd_pkg::FILL_IDLE: begin
          if (accept) begin
            if (fill_len == '0) begin
              fill_done <= 1'b1;  // Empty fill finishes at once
            end else begin
              state  <= mem_cmd_pkg::FILL_RUN;
              remain <= fill_len;
            end
          end
        end
        default: begin
          remain <= remain - 1'b1;
          if (remain == mem_cfg_pkg::LEN_W'(1)) begin  // Last word this cycle
            state     <= mem_cmd_pkg::FILL_IDLE;
            fill_done <= 1'b1;
          end
        end
      endcase
    end
  end

  // Address and pattern
  always_ff @(posedge clka) begin
    if (accept) begin
      cur_addr <= fill_addr;
      pattern  <= fill_data;
    end else if (busy) begin
      cur_addr <= next_addr;
    end
  end

  // An accepted request starts writing at its own address the next cycle
  a_fill_starts : assert property (
    @(posedge clka) disable iff (reset)
    accept && (fill_len != '0) |=> port_b.en && (port_b.addr == $past(fill_addr))
  ) else $error("Accepted fill did not start at the requested address");

endmodule

// File: logic/mem_cfg_pkg.sv
// RAM geometry shared by the memory command engine
// Widths for ports, interfaces and the RAM come from here

package mem_cfg_pkg;

  // Byte columns per word
  localparam int NB_COL = 4;

  localparam int COL_WIDTH = 9;                // Bits per column, parity-style 9-bit bytes
  localparam int WORD_W = NB_COL * COL_WIDTH;  // 36-bit word

  // Word count and matching address width
  localparam int RAM_DEPTH = 1024;
  localparam int ADDR_W = $clog2(RAM_DEPTH);

  // Fill length needs one more bit so a fill can cover every word
  localparam int LEN_W = ADDR_W + 1;

endpackage

// File: logic/mem_cmd_pkg.sv
// Command and state encodings for the memory command engine
// Host opcodes and the fill engine states

package mem_cmd_pkg;

  // Host opcodes, 2 bits on the cmd_op port
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,  // Read one word on port A
    OP_WRITE = 2'd1,  // Masked write on port A, returns merged word
    OP_FILL  = 2'd2,  // Background pattern fill on port B
    OP_RSVD  = 2'd3   // Illegal, answered with err
  } mem_op_t;

  // Fill engine states
  typedef enum logic {
    FILL_IDLE = 1'b0,  // Waiting for a request
    FILL_RUN  = 1'b1   // Writing one word per cycle
  } fill_state_t;

endpackage

// File: logic/mem_engine_top.sv
// Memory command engine top level
// Host strobes in, registered responses out; FILL runs on port B in
// the background while READ and WRITE use port A

module mem_engine_top (
  input  logic                           clka,
  input  logic                           reset,
  input  logic                           cmd_valid,
  input  logic [1:0]                     cmd_op,
  input  logic [mem_cfg_pkg::ADDR_W-1:0] cmd_addr,
  input  logic [mem_cfg_pkg::WORD_W-1:0] cmd_data,
  input  logic [mem_cfg_pkg::NB_COL-1:0] cmd_be,
  input  logic [mem_cfg_pkg::LEN_W-1:0]  cmd_len,
  output logic                           rsp_valid,
  output logic [mem_cfg_pkg::WORD_W-1:0] rsp_data,
  output logic                           err,
  output logic                           busy,
  output logic                           fill_done
);

  logic                           fill_start;
  logic [mem_cfg_pkg::ADDR_W-1:0] fill_addr;
  logic [mem_cfg_pkg::WORD_W-1:0] fill_data;
  logic [mem_cfg_pkg::LEN_W-1:0]  fill_len;
  logic                           rd_tag;
  logic                           bad_op_tag;
  logic                           fill_reject;

  mem_port_if port_a ();  // Host READ and WRITE
  mem_port_if port_b ();  // Fill engine

  bytewrite_tdp_ram ram_i (
    .clka (clka),
    .a    (port_a),
    .b    (port_b)
  );

  cmd_decode decode_i (
    .clka       (clka),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_addr   (cmd_addr),
    .cmd_data   (cmd_data),
    .cmd_be     (cmd_be),
    .cmd_len    (cmd_len),
    .port_a     (port_a),
    .fill_start (fill_start),
    .fill_addr  (fill_addr),
    .fill_data  (fill_data),
    .fill_len   (fill_len),
    .rd_tag     (rd_tag),
    .bad_op_tag (bad_op_tag)
  );

  fill_execute fill_i (
    .clka        (clka),
    .reset       (reset),
    .fill_start  (fill_start),
    .fill_addr   (fill_addr),
    .fill_data   (fill_data),
    .fill_len    (fill_len),
    .port_b      (port_b),
    .busy        (busy),
    .fill_done   (fill_done),
    .fill_reject (fill_reject)
  );

  result_stage result_i (
    .clka        (clka),
    .reset       (reset),
    .rd_tag      (rd_tag),
    .bad_op_tag  (bad_op_tag),
    .fill_reject (fill_reject),
    .port_a_dout (port_a.dout),  // Port B read data is unused
    .rsp_valid   (rsp_valid),
    .rsp_data    (rsp_data),
    .err         (err)
  );

endmodule

// File: logic/mem_port_if.sv
// One port of the byte-write RAM
// user side drives the access, ram side returns read data

interface mem_port_if #(
  parameter int NB_COL = mem_cfg_pkg::NB_COL,
  parameter int ADDR_W = mem_cfg_pkg::ADDR_W,
  parameter int WORD_W = mem_cfg_pkg::WORD_W
);

  logic              en;    // Port enable, read or write
  logic [NB_COL-1:0] we;    // Byte column write mask
  logic [ADDR_W-1:0] addr;  // Word address
  logic [WORD_W-1:0] din;   // Write data
  logic [WORD_W-1:0] dout;  // Registered read data, write-first

  // Requester side
  modport user (
    output en,
    output we,
    output addr,
    output din,
    input  dout
  );

  // Memory side
  modport ram (
    input  en,
    input  we,
    input  addr,
    input  din,
    output dout
  );

endinterface

// File: logic/result_stage.sv
// Response stage
// Lines the command tags up with RAM read data and registers the host
// response and error pulses, three cycles after the command strobe

module result_stage (
  input  logic                           clka,
  input  logic                           reset,
  input  logic                           rd_tag,       // Aligned with port A enable
  input  logic                           bad_op_tag,
  input  logic                           fill_reject,  // Already one cycle later
  input  logic [mem_cfg_pkg::WORD_W-1:0] port_a_dout,
  output logic                           rsp_valid,
  output logic [mem_cfg_pkg::WORD_W-1:0] rsp_data,
  output logic                           err
);

  logic rd_d;   // rd_tag lined up with dout
  logic bad_d;

  always_ff @(posedge clka) begin
    if (reset) begin
      rd_d      <= 1'b0;
      bad_d     <= 1'b0;
      rsp_valid <= 1'b0;
      err       <= 1'b0;
    end else begin
      rd_d      <= rd_tag;
      bad_d     <= bad_op_tag;
      rsp_valid <= rd_d;
      err       <= bad_d || fill_reject;  // Both causes arrive in the same cycle
    end
  end

  // Data register follows the valid flag
  always_ff @(posedge clka) begin
    if (rd_d) begin
      rsp_data <= port_a_dout;
    end
  end

  // One command per cycle, so a response slot carries data or an error
  a_rsp_err_exclusive : assert property (
    @(posedge clka) disable iff (reset)
    !(rsp_valid && err)
  ) else $error("rsp_valid and err raised for the same command slot");

endmodule

// File: test/mem_engine_tb.sv
// Testbench for the memory command engine
// A shadow memory and a 3-stage expected-response line feed the checking
// assertions; busy and fill_done are checked against edge-indexed fill windows

module mem_engine_tb;

  localparam int W   = mem_cfg_pkg::WORD_W;
  localparam int CW  = mem_cfg_pkg::COL_WIDTH;
  localparam int NB  = mem_cfg_pkg::NB_COL;
  localparam int DEP = mem_cfg_pkg::RAM_DEPTH;
  localparam int AW  = mem_cfg_pkg::ADDR_W;
  localparam int LW  = mem_cfg_pkg::LEN_W;

  logic                           clka, reset, cmd_valid;
  logic [1:0]                     cmd_op;
  logic [mem_cfg_pkg::ADDR_W-1:0] cmd_addr;
  logic [W-1:0]                   cmd_data, rsp_data;
  logic [NB-1:0]                  cmd_be;
  logic [mem_cfg_pkg::LEN_W-1:0]  cmd_len;
  logic                           rsp_valid, err, busy, fill_done;

  logic [W-1:0] shadow [DEP];  // Expected RAM contents
  logic         nxt_v, nxt_e;  // Expectation for the command on the inputs
  logic [W-1:0] nxt_d;
  logic [2:0]   pv, pe;        // Bit 2 lines up with the response cycle
  logic [W-1:0] pd [3];
  int           cyc, errors, seed, flen;
  int           f_first, f_last, done_at;  // Busy window and done edge of the fill

  mem_engine_top dut_i (.*);

  initial begin
    clka = 1'b0;
    forever #50 clka = ~clka;
  end

  // Edge counter and expected-response delay line
  always @(posedge clka) begin
    cyc   <= cyc + 1;
    pv    <= reset ? 3'b0 : {pv[1:0], nxt_v};
    pe    <= reset ? 3'b0 : {pe[1:0], nxt_e};
    pd[0] <= nxt_d;
    for (int i = 1; i < 3; i++) pd[i] <= pd[i-1];
  end

  // Counts one failed check and prints it with the time
  task automatic report_error(input string msg);
    errors++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  a_reset_quiet : assert property (@(posedge clka)
    $fell(reset) |-> !(rsp_valid || err || busy || fill_done))
    else report_error("outputs active after reset");
  a_rsp_valid : assert property (@(posedge clka) disable iff (reset) rsp_valid == pv[2])
    else report_error($sformatf("rsp_valid is %b", $sampled(rsp_valid)));
  a_rsp_data : assert property (@(posedge clka) disable iff (reset) pv[2] |-> rsp_data === pd[2])
    else report_error($sformatf("rsp_data %h, expected %h", $sampled(rsp_data), $sampled(pd[2])));
  a_err : assert property (@(posedge clka) disable iff (reset) err == pe[2])
    else report_error($sformatf("err is %b", $sampled(err)));
  a_busy : assert property (@(posedge clka) disable iff (reset)
    busy == (cyc >= f_first && cyc <= f_last))
    else report_error($sformatf("busy is %b", $sampled(busy)));
  a_fill_done : assert property (@(posedge clka) disable iff (reset) fill_done == (cyc == done_at))
    else report_error($sformatf("fill_done is %b", $sampled(fill_done)));

  function automatic logic [W-1:0] rand_word();
    rand_word = W'({$random(seed), $random(seed)});  // Upper bits drop off
  endfunction

  // Byte-write rule, new columns where the mask is set
  function automatic logic [W-1:0] merge_word(input logic [W-1:0] old_w,
                                               input logic [W-1:0] new_w,
                                               input logic [NB-1:0] be);
    logic [W-1:0] res;
    res = old_w;
    for (int i = 0; i < NB; i++) if (be[i]) res[i*CW +: CW] = new_w[i*CW +: CW];
    return res;
  endfunction

  // One command per call, sampled by the DUT at the next edge
  task automatic send_cmd(input logic [1:0] op, input int addr, input logic [W-1:0] data,
                          input logic [NB-1:0] be, input int len);
    int d;
    @(posedge clka);
    d = cyc;
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    cmd_addr  <= AW'(addr);
    cmd_data  <= data;
    cmd_be    <= be;
    cmd_len   <= LW'(len);
    if (op == mem_cmd_pkg::OP_WRITE) shadow[addr] = merge_word(shadow[addr], data, be);
    nxt_v <= (op == mem_cmd_pkg::OP_READ) || (op == mem_cmd_pkg::OP_WRITE);
    nxt_d <= shadow[addr];
    if (op == mem_cmd_pkg::OP_RSVD) begin
      nxt_e <= 1'b1;
    end else if (op == mem_cmd_pkg::OP_FILL && d + 2 >= f_first && d + 2 <= f_last) begin
      nxt_e <= 1'b1;  // Engine still running, request dropped
    end else begin
      nxt_e <= 1'b0;
      if (op == mem_cmd_pkg::OP_FILL) begin
        for (int i = 0; i < len; i++) shadow[(addr + i) % DEP] = data;
        f_first = d + 3;  // Writes at sample edges N+2 .. N+1+L
        f_last  = d + 2 + len;
        done_at = d + 3 + len;
      end
    end
  endtask

  task automatic go_idle();
    @(posedge clka);
    cmd_valid <= 1'b0;
    nxt_v     <= 1'b0;
    nxt_e     <= 1'b0;
  endtask

  task automatic wait_fill_done(input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clka);
      n++;
    end while (fill_done !== 1'b1 && n < limit);
    if (fill_done !== 1'b1) begin
      errors++;
      $display("Timeout: fill_done did not pulse within %0d cycles", limit);
    end
  endtask

  initial begin
    seed      = 18;
    errors    = 0;
    cyc       = 0;
    f_first   = 1;
    f_last    = 0;
    done_at   = -1;
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = '0;
    cmd_addr  = '0;
    cmd_data  = '0;
    cmd_be    = '0;
    cmd_len   = '0;
    nxt_v     = 1'b0;
    nxt_e     = 1'b0;
    nxt_d     = '0;
    repeat (3) @(posedge clka);
    reset <= 1'b0;
    // Full words, then random masks, then back-to-back reads
    for (int a = 16; a < 24; a++) send_cmd(mem_cmd_pkg::OP_WRITE, a, rand_word(), '1, 0);
    for (int a = 16; a < 24; a++) begin
      send_cmd(mem_cmd_pkg::OP_WRITE, a, rand_word(), NB'($random(seed)), 0);
    end
    for (int a = 16; a < 24; a++) send_cmd(mem_cmd_pkg::OP_READ, a, '0, '0, 0);
    // Fill that wraps past the top address, a second fill while busy, host traffic alongside
    flen = 6 + ($random(seed) & 3);
    send_cmd(mem_cmd_pkg::OP_FILL, DEP - 4, rand_word(), '0, flen);
    send_cmd(mem_cmd_pkg::OP_FILL, 16, rand_word(), '0, 4);
    send_cmd(mem_cmd_pkg::OP_WRITE, 16, rand_word(), NB'($random(seed)), 0);
    send_cmd(mem_cmd_pkg::OP_WRITE, 17, rand_word(), '1, 0);
    send_cmd(mem_cmd_pkg::OP_READ, 16, '0, '0, 0);
    send_cmd(mem_cmd_pkg::OP_READ, 17, '0, '0, 0);
    go_idle();
    wait_fill_done(40);
    for (int i = 0; i < flen; i++) begin
      send_cmd(mem_cmd_pkg::OP_READ, (DEP - 4 + i) % DEP, '0, '0, 0);
    end
    // Untouched by rejected fill
    for (int a = 16; a < 20; a++) send_cmd(mem_cmd_pkg::OP_READ, a, '0, '0, 0);
    // Empty fill and an illegal opcode
    send_cmd(mem_cmd_pkg::OP_FILL, 40, rand_word(), '0, 0);
    go_idle();
    wait_fill_done(10);
    send_cmd(mem_cmd_pkg::OP_RSVD, 20, '0, '0, 0);
    go_idle();
    repeat (6) @(posedge clka);  // Drain the 3-cycle response pipe
    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
